// File: logic/ks10Pkg.sv
/* KS-10 Dispatch Definitions */

package ks10Pkg;

   ////////////////////
   // Widths
   ////////////////////

   // Micro address width
   localparam int UADDR_W = 12;
   // Next instruction dispatch width, merged into low micro address bits
   localparam int NI_W = 4;

   ////////////////////
   // PC flags, bits 0 to 17
   ////////////////////

   // First field is bit 0, the most significant
   typedef struct packed {
      logic       aro;      // Arithmetic overflow
      logic       cy0;      // Carry 0
      logic       cy1;      // Carry 1
      logic       fov;      // Floating overflow
      logic       fpd;      // First part done
      logic       user;     // User mode
      logic       userIo;   // User I/O
      logic       pcu;      // Previous context user
      logic       spare8;
      logic       trap2;    // Bit 9
      logic       trap1;    // Bit 10
      logic       fxu;      // Floating underflow
      logic       ndv;      // No divide
      logic [0:4] rsvd;     // Bits 13 to 17
   } pcFlagsT;

   ////////////////////
   // APR flags, bits 22 to 35
   ////////////////////

   typedef struct packed {
      logic       trapEn;   // Bit 22
      logic [0:7] intEn;    // Interrupt enables, bits 23 to 30
      logic [0:4] rsvd;     // Bits 31 to 35
   } aprFlagsT;

   // Dispatch word, fetch bit on top
   typedef struct packed {
      logic       fetch;
      logic [2:0] code;
   } niDispT;

   typedef logic [UADDR_W-1:0] uAddrT;

   ////////////////////
   // Dispatch codes
   ////////////////////

   localparam logic [2:0] NI_TRAP3  = 3'o1;
   localparam logic [2:0] NI_TRAP2  = 3'o2;
   localparam logic [2:0] NI_TRAP1  = 3'o3;
   localparam logic [2:0] NI_HALT   = 3'o5;
   localparam logic [2:0] NI_NORMAL = 3'o7;

   // Micro PC after reset
   localparam uAddrT RESET_UADDR = '0;

endpackage

// File: logic/niDisp.sv
/* Next Instruction Dispatch */

`timescale 1ns/1ps

module niDisp
(
   input  logic            trap1,
   input  logic            trap2,
   input  logic            trapEn,
   input  logic            consTrapEn,
   input  logic            cpuRun,
   input  logic            memCycle,
   output ks10Pkg::niDispT dispNi
);

   import ks10Pkg::*;

   // Traps only honoured with both enables up
   logic       trapOk;
   logic [2:0] code;

   assign trapOk = consTrapEn & trapEn;

   ////////////////////
   // Code selection
   ////////////////////

   // Trap codes outrank halt and normal
   always_comb
   begin
      if (trapOk && trap1 && trap2)
      begin
         code = NI_TRAP3;
      end
      else if (trapOk && trap2)
      begin
         code = NI_TRAP2;
      end
      else if (trapOk && trap1)
      begin
         code = NI_TRAP1;
      end
      else if (!cpuRun)
      begin
         // Stopped, go to the halt loop
         code = NI_HALT;
      end
      else
      begin
         code = NI_NORMAL;
      end
   end

   // Fetch in progress
   assign dispNi.fetch = memCycle;
   assign dispNi.code  = code;

   // Unused codes 0, 4 and 6 never leave this block
   always_comb
   begin
      if (!$isunknown(code))
      begin
         assert (!(code inside {3'o0, 3'o4, 3'o6}))
            else $error("niDisp: illegal dispatch code %0o", code);
      end
   end

endmodule

// File: logic/pcFlags.sv
/* PC Flag Register */

`timescale 1ns/1ps

module pcFlags
(
   input  logic             clk,
   input  logic             arstN,
   input  logic             setTrap1,
   input  logic             setTrap2,
   input  logic             trapClear,
   input  logic             pcLoad,
   input  ks10Pkg::pcFlagsT pcLoadData,
   output ks10Pkg::pcFlagsT pcFlagsQ
);

   import ks10Pkg::*;

   pcFlagsT flagsNext;

   ////////////////////
   // Next state
   ////////////////////

   // Load, then clear, then set
   always_comb
   begin
      flagsNext = pcFlagsQ;
      if (pcLoad)
      begin
         // Whole word replaced
         flagsNext = pcLoadData;
      end
      else if (trapClear)
      begin
         // Trap taken by the microsequencer
         flagsNext.trap1 = 1'b0;
         flagsNext.trap2 = 1'b0;
      end
      else
      begin
         if (setTrap1)
         begin
            flagsNext.trap1 = 1'b1;
         end
         if (setTrap2)
         begin
            flagsNext.trap2 = 1'b1;
         end
      end
   end

   // Flag register
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         pcFlagsQ <= '0;
      end
      else
      begin
         pcFlagsQ <= flagsNext;
      end
   end

   // Clear with nothing competing empties both trap bits
   assert property (@(posedge clk) disable iff (!arstN)
      (trapClear && !pcLoad && !setTrap1 && !setTrap2)
      |=> (!pcFlagsQ.trap1 && !pcFlagsQ.trap2))
      else $error("pcFlags: trap bits survived a trap clear");

endmodule

// File: logic/aprFlags.sv
/* APR Flag Register */

`timescale 1ns/1ps

module aprFlags
(
   input  logic              clk,
   input  logic              arstN,
   input  logic              aprWrite,
   input  ks10Pkg::aprFlagsT aprSetMask,
   input  ks10Pkg::aprFlagsT aprClrMask,
   output ks10Pkg::aprFlagsT aprFlagsQ
);

   import ks10Pkg::*;

   aprFlagsT flagsNext;
   aprFlagsT bothMask;

   ////////////////////
   // Mask write
   ////////////////////

   // Clear beats set on a shared bit
   always_comb
   begin
      flagsNext = aprFlagsQ;
      if (aprWrite)
      begin
         flagsNext = (aprFlagsQ | aprSetMask) & ~aprClrMask;
      end
   end

   // Bits named in both masks
   assign bothMask = aprSetMask & aprClrMask;

   // Flag register
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         aprFlagsQ <= '0;
      end
      else
      begin
         aprFlagsQ <= flagsNext;
      end
   end

   // A bit in both masks reads zero after the write
   assert property (@(posedge clk) disable iff (!arstN)
      aprWrite |=> ((aprFlagsQ & $past(bothMask)) == '0))
      else $error("aprFlags: set won over clear");

endmodule

// File: logic/microSeq.sv
/* Micro PC Sequencer */

`timescale 1ns/1ps

module microSeq
(
   input  logic            clk,
   input  logic            arstN,
   input  logic            dispatchReq,
   input  ks10Pkg::uAddrT  jumpAddr,
   input  ks10Pkg::niDispT dispNi,
   output ks10Pkg::uAddrT  uPc,
   output logic            trapTaken
);

   import ks10Pkg::*;

   uAddrT uPcNext;
   logic  trapCode;
   logic  trapDisp;

   ////////////////////
   // Address merge
   ////////////////////

   // Dispatch ORs the code into the low bits of the jump
   always_comb
   begin
      uPcNext = jumpAddr;
      if (dispatchReq)
      begin
         uPcNext[NI_W-1:0] = jumpAddr[NI_W-1:0] | dispNi;
      end
   end

   // Any of the three trap codes
   assign trapCode = (dispNi.code == NI_TRAP3) ||
                     (dispNi.code == NI_TRAP2) ||
                     (dispNi.code == NI_TRAP1);

   // Only a dispatch actually takes the trap
   assign trapDisp = dispatchReq & trapCode;

   // Micro PC and trap pulse
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         uPc       <= RESET_UADDR;
         trapTaken <= 1'b0;
      end
      else
      begin
         uPc       <= uPcNext;
         // Feeds the trap clear in the PC flags
         trapTaken <= trapDisp;
      end
   end

   // Back to back trap pulses need back to back dispatches
   assert property (@(posedge clk) disable iff (!arstN)
      (trapTaken && $past(trapTaken))
      |-> ($past(dispatchReq) && $past(dispatchReq, 2)))
      else $error("microSeq: trapTaken stretched without dispatch");

endmodule

// File: logic/cpuDispatch.sv
/* CPU Dispatch Top */

`timescale 1ns/1ps

module cpuDispatch
(
   input  logic              clk,
   input  logic              arstN,
   // Levels
   input  logic              consTrapEn,
   input  logic              cpuRun,
   input  logic              memCycle,
   // Trap request pulses
   input  logic              setTrap1,
   input  logic              setTrap2,
   // PC flag load
   input  logic              pcLoad,
   input  ks10Pkg::pcFlagsT  pcLoadData,
   // APR flag write
   input  logic              aprWrite,
   input  ks10Pkg::aprFlagsT aprSetMask,
   input  ks10Pkg::aprFlagsT aprClrMask,
   // Microword fields
   input  logic              dispatchReq,
   input  ks10Pkg::uAddrT    jumpAddr,
   // Results
   output ks10Pkg::niDispT   dispNi,
   output ks10Pkg::uAddrT    uPc,
   output logic              trapTaken,
   output ks10Pkg::pcFlagsT  pcFlagsQ,
   output ks10Pkg::aprFlagsT aprFlagsQ
);

   ////////////////////
   // Flag registers
   ////////////////////

   // Taken trap clears its own request
   pcFlags i_pcFlags
   (
      .clk        (clk),
      .arstN      (arstN),
      .setTrap1   (setTrap1),
      .setTrap2   (setTrap2),
      .trapClear  (trapTaken),
      .pcLoad     (pcLoad),
      .pcLoadData (pcLoadData),
      .pcFlagsQ   (pcFlagsQ)
   );

   aprFlags i_aprFlags
   (
      .clk        (clk),
      .arstN      (arstN),
      .aprWrite   (aprWrite),
      .aprSetMask (aprSetMask),
      .aprClrMask (aprClrMask),
      .aprFlagsQ  (aprFlagsQ)
   );

   // Combinational dispatch code
   niDisp i_niDisp
   (
      .trap1      (pcFlagsQ.trap1),
      .trap2      (pcFlagsQ.trap2),
      .trapEn     (aprFlagsQ.trapEn),
      .consTrapEn (consTrapEn),
      .cpuRun     (cpuRun),
      .memCycle   (memCycle),
      .dispNi     (dispNi)
   );

   // Micro PC
   microSeq i_microSeq
   (
      .clk         (clk),
      .arstN       (arstN),
      .dispatchReq (dispatchReq),
      .jumpAddr    (jumpAddr),
      .dispNi      (dispNi),
      .uPc         (uPc),
      .trapTaken   (trapTaken)
   );

endmodule

// File: sim/cpuDispatchTb.sv
/* CPU Dispatch Testbench */

`timescale 1ns/1ps

module cpuDispatchTb;

   import ks10Pkg::*;

   // One step, inputs then expected results
   typedef struct packed {
      logic     cte, run, mem, st1, st2, pcl;
      pcFlagsT  pcData;
      logic     apw;
      aprFlagsT aset, aclr;
      logic     dreq;
      uAddrT    jump;
      niDispT   expDisp;
      uAddrT    expUpc;
      logic     expTt, expT1, expT2;
      aprFlagsT expApr;
      pcFlagsT  expPc;
      logic     fullPc;
   } stepT;

   logic     clk;
   logic     arstN;
   logic     consTrapEn, cpuRun, memCycle;
   logic     setTrap1, setTrap2, pcLoad, aprWrite, dispatchReq;
   pcFlagsT  pcLoadData;
   aprFlagsT aprSetMask, aprClrMask;
   uAddrT    jumpAddr;
   niDispT   dispNi;
   uAddrT    uPc;
   logic     trapTaken;
   pcFlagsT  pcFlagsQ;
   aprFlagsT aprFlagsQ;

   stepT        cases[$];
   pcFlagsT     refPc;
   aprFlagsT    refApr;
   logic        refTt;
   logic [31:0] rng;
   int          stepNo;
   int          checkCount;
   int          errCount;
   int          watchNs;
   int          randSteps = 400;
   logic        casesLoaded = 1'b0;

   cpuDispatch i_cpuDispatch (.*);

   // 8 ns clock
   always #4 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic compareHex(input string name, input logic [31:0] got, input logic [31:0] exp);
      checkCount++;
      assert (got === exp)
      else
      begin
         errCount++;
         $display("MISMATCH %s at step %0d: got %0h, expected %0h", name, stepNo, got, exp);
      end
   endtask

   ////////////////////
   // Reference model
   ////////////////////

   // Armed traps first, then run level
   function automatic niDispT expectDisp(input pcFlagsT pc, input aprFlagsT apr,
                                         input logic cte, input logic run, input logic mem);
      niDispT d;
      logic   armed;
      armed   = cte & apr.trapEn;
      d.fetch = mem;
      case ({armed & pc.trap1, armed & pc.trap2})
         2'b11:   d.code = NI_TRAP3;
         2'b01:   d.code = NI_TRAP2;
         2'b10:   d.code = NI_TRAP1;
         default: d.code = run ? NI_NORMAL : NI_HALT;
      endcase
      return d;
   endfunction

   // Predicts one edge and moves the model state on
   task automatic advanceModel(input stepT s, output stepT p);
      pcFlagsT nextPc;
      p         = s;
      p.expDisp = expectDisp(refPc, refApr, s.cte, s.run, s.mem);
      p.expUpc  = s.jump;
      if (s.dreq)
         p.expUpc[3:0] = s.jump[3:0] | p.expDisp;
      p.expTt = s.dreq && (p.expDisp.code inside {NI_TRAP1, NI_TRAP2, NI_TRAP3});
      nextPc  = refPc;
      // Load, then clear from last pulse, then set
      if (s.pcl)
         nextPc = s.pcData;
      else if (refTt)
      begin
         nextPc.trap1 = 1'b0;
         nextPc.trap2 = 1'b0;
      end
      else
      begin
         nextPc.trap1 = nextPc.trap1 | s.st1;
         nextPc.trap2 = nextPc.trap2 | s.st2;
      end
      if (s.apw)
         refApr = (refApr & ~s.aclr) | (s.aset & ~s.aclr);
      refPc    = nextPc;
      refTt    = p.expTt;
      p.expPc  = nextPc;
      p.expT1  = nextPc.trap1;
      p.expT2  = nextPc.trap2;
      p.expApr = refApr;
      p.fullPc = 1'b1;
   endtask

   ////////////////////
   // Stimulus
   ////////////////////

   // Called on a falling edge, returns on the next one
   task automatic runStep(input stepT s);
      consTrapEn  = s.cte;
      cpuRun      = s.run;
      memCycle    = s.mem;
      setTrap1    = s.st1;
      setTrap2    = s.st2;
      pcLoad      = s.pcl;
      pcLoadData  = s.pcData;
      aprWrite    = s.apw;
      aprSetMask  = s.aset;
      aprClrMask  = s.aclr;
      dispatchReq = s.dreq;
      jumpAddr    = s.jump;
      // Code settles well before the rising edge
      #2;
      compareHex("dispNi", 32'(dispNi), 32'(s.expDisp));
      @(negedge clk);
      compareHex("uPc", 32'(uPc), 32'(s.expUpc));
      compareHex("trapTaken", 32'(trapTaken), 32'(s.expTt));
      compareHex("pcFlagsQ.trap1", 32'(pcFlagsQ.trap1), 32'(s.expT1));
      compareHex("pcFlagsQ.trap2", 32'(pcFlagsQ.trap2), 32'(s.expT2));
      compareHex("aprFlagsQ", 32'(aprFlagsQ), 32'(s.expApr));
      if (s.fullPc)
         compareHex("pcFlagsQ", 32'(pcFlagsQ), 32'(s.expPc));
      stepNo++;
   endtask

   // Strobes sparse, levels mostly high
   task automatic randomStep(output stepT s);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      rng      = xorshift(rng);
      a        = rng;
      rng      = xorshift(rng);
      b        = rng;
      rng      = xorshift(rng);
      c        = rng;
      s        = '0;
      s.cte    = a[0] | a[1];
      s.run    = a[2] | a[3];
      s.mem    = a[4];
      s.st1    = a[5] & a[6];
      s.st2    = a[7] & a[8];
      s.pcl    = (a[11:9] == 3'd0);
      s.apw    = (a[14:12] == 3'd0);
      s.dreq   = a[15] | a[16];
      s.jump   = b[11:0];
      s.pcData = b[29:12];
      s.aset   = c[13:0];
      s.aclr   = c[27:14] & a[30:17];
   endtask

   task automatic loadCases();
      int          fd;
      string       line;
      stepT        s;
      logic [31:0] vCte, vRun, vMem, vSt1, vSt2, vPcl, vPcData, vApw, vSet;
      logic [31:0] vClr, vDreq, vJump, vDisp, vUpc, vTt, vT1, vT2, vApr;
      fd = $fopen("sim/dispatchCases.txt", "r");
      if (fd == 0)
      begin
         errCount++;
         $display("Could not open the case file sim/dispatchCases.txt");
         return;
      end
      while ($fgets(line, fd) != 0)
      begin
         // Skip comments and blank lines
         if (line.len() < 2 || line.getc(0) == "#")
            continue;
         if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     vCte, vRun, vMem, vSt1, vSt2, vPcl, vPcData, vApw, vSet,
                     vClr, vDreq, vJump, vDisp, vUpc, vTt, vT1, vT2, vApr) != 18)
         begin
            errCount++;
            $display("Case file line has the wrong number of columns: %s", line);
            continue;
         end
         s         = '0;
         s.cte     = vCte[0];
         s.run     = vRun[0];
         s.mem     = vMem[0];
         s.st1     = vSt1[0];
         s.st2     = vSt2[0];
         s.pcl     = vPcl[0];
         s.pcData  = vPcData[17:0];
         s.apw     = vApw[0];
         s.aset    = vSet[13:0];
         s.aclr    = vClr[13:0];
         s.dreq    = vDreq[0];
         s.jump    = vJump[11:0];
         s.expDisp = vDisp[3:0];
         s.expUpc  = vUpc[11:0];
         s.expTt   = vTt[0];
         s.expT1   = vT1[0];
         s.expT2   = vT2[0];
         s.expApr  = vApr[13:0];
         cases.push_back(s);
      end
      $fclose(fd);
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial
   begin
      stepT s;
      stepT p;
      clk         = 1'b0;
      arstN       = 1'b0;
      consTrapEn  = 1'b0;
      cpuRun      = 1'b0;
      memCycle    = 1'b0;
      setTrap1    = 1'b0;
      setTrap2    = 1'b0;
      pcLoad      = 1'b0;
      pcLoadData  = '0;
      aprWrite    = 1'b0;
      aprSetMask  = '0;
      aprClrMask  = '0;
      dispatchReq = 1'b0;
      jumpAddr    = '0;
      refPc       = '0;
      refApr      = '0;
      refTt       = 1'b0;
      rng         = 32'd56399;
      stepNo      = 0;
      checkCount  = 0;
      errCount    = 0;
      loadCases();
      // Reset, file steps, random steps, plus slack
      watchNs     = (10 + cases.size() + randSteps + 2) * 8 + 400;
      casesLoaded = 1'b1;
      repeat (10) @(negedge clk);
      arstN = 1'b1;
      compareHex("uPc", 32'(uPc), 32'(RESET_UADDR));
      compareHex("trapTaken", 32'(trapTaken), 32'd0);
      compareHex("pcFlagsQ", 32'(pcFlagsQ), 32'd0);
      compareHex("aprFlagsQ", 32'(aprFlagsQ), 32'd0);
      // Directed steps, model kept in step for the random phase
      foreach (cases[i])
      begin
         advanceModel(cases[i], p);
         runStep(cases[i]);
      end
      repeat (randSteps)
      begin
         randomStep(s);
         advanceModel(s, p);
         runStep(p);
      end
      $display("Checks: %0d, errors: %0d", checkCount, errCount);
      if (errCount == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   // Watchdog, sized once the cases are known
   initial
   begin
      wait (casesLoaded === 1'b1);
      #(watchNs);
      errCount++;
      $display("Timeout: run still going after %0d ns", watchNs);
      $display("Checks: %0d, errors: %0d", checkCount, errCount);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: list.f
logic/ks10Pkg.sv
logic/niDisp.sv
logic/pcFlags.sv
logic/aprFlags.sv
logic/microSeq.sv
logic/cpuDispatch.sv
sim/cpuDispatchTb.sv

// File: run.sh
#!/bin/sh
# Build and run the dispatch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   -f list.f \
   --top-module cpuDispatchTb \
   -Mdir obj_dir

./obj_dir/VcpuDispatchTb > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"

// File: sim/dispatchCases.txt
# cte run mem setTrap1 setTrap2 pcLoad pcLoadData aprWrite aprSetMask aprClrMask dispatchReq jumpAddr
# then dispNi (before the edge), uPc trapTaken trap1 trap2 aprFlagsQ (after the edge), all hex
# Reset state, halt and normal, fetch bit
0 1 0 0 0 0 00000 0 0000 0000 0 000  7 000 0 0 0 0000
0 0 0 0 0 0 00000 0 0000 0000 0 000  5 000 0 0 0 0000
0 1 0 0 0 0 00000 0 0000 0000 1 120  7 127 0 0 0 0000
0 1 1 0 0 0 00000 0 0000 0000 0 345  f 345 0 0 0 0000
# Trap bits ignored until both enables are up
0 1 0 1 0 0 00000 0 0000 0000 0 200  7 200 0 1 0 0000
0 1 0 0 0 0 00000 0 0000 0000 1 200  7 207 0 1 0 0000
1 1 0 0 0 0 00000 1 2000 0000 0 010  7 010 0 1 0 2000
1 1 0 0 0 0 00000 0 0000 0000 0 050  3 050 0 1 0 2000
# Trap over halt, then both traps taken and cleared
1 0 1 0 1 0 00000 0 0000 0000 0 060  b 060 0 1 1 2000
1 1 0 0 0 0 00000 0 0000 0000 1 330  1 331 1 1 1 2000
1 1 0 0 0 0 00000 0 0000 0000 0 400  1 400 0 0 0 2000
1 1 0 0 0 0 00000 0 0000 0000 0 401  7 401 0 0 0 2000
# Trap2 alone, then a load beats the clear
1 1 0 0 1 0 00000 0 0000 0000 0 002  7 002 0 0 1 2000
1 1 0 0 0 0 00000 0 0000 0000 1 7f0  2 7f2 1 0 1 2000
1 1 0 0 0 1 20180 0 0000 0000 0 100  2 100 0 1 1 2000
1 1 0 0 0 0 00000 0 0000 0000 0 0a0  1 0a0 0 1 1 2000
# Clear beats new set pulses
1 1 0 0 0 0 00000 0 0000 0000 1 010  1 011 1 1 1 2000
1 1 0 1 1 0 00000 0 0000 0000 0 000  1 000 0 0 0 2000
# APR clear wins over set on trapEn
1 1 0 1 0 0 00000 1 2000 2000 0 222  7 222 0 1 0 0000
1 1 0 0 0 0 00000 0 0000 0000 1 300  7 307 0 1 0 0000
1 1 0 0 0 0 00000 1 2000 0000 0 300  7 300 0 1 0 2000
1 1 1 0 0 0 00000 0 0000 0000 1 ff0  b ffb 1 1 0 2000
0 0 0 0 0 0 00000 0 0000 0000 1 800  5 805 0 0 0 2000
0 0 1 0 0 0 00000 0 0000 0000 0 123  d 123 0 0 0 2000
# Interrupt enable masks
1 1 0 0 0 0 00000 1 1fe0 0000 0 456  7 456 0 0 0 3fe0
1 1 0 0 0 0 00000 1 0000 0f00 0 789  7 789 0 0 0 30e0
1 1 0 0 0 0 00000 1 0f01 0101 1 9a0  7 9a7 0 0 0 3ee0
1 1 0 0 0 0 00000 0 0001 2000 0 bcd  7 bcd 0 0 0 3ee0
1 1 0 0 1 0 00000 1 0000 2000 0 def  7 def 0 0 1 1ee0
1 1 0 0 0 0 00000 0 0000 0000 1 5a8  7 5af 0 0 1 1ee0
1 1 0 0 0 1 00000 0 0000 0000 0 001  7 001 0 0 0 1ee0
0 1 1 0 0 0 00000 0 0000 0000 1 000  f 00f 0 0 0 1ee0
